// File: csr_engine_cfg.svh
// Build-time constants of the CSR index engine, included by every RTL file that needs them
`ifndef CSR_ENGINE_CFG_SVH
`define CSR_ENGINE_CFG_SVH

// FIFO sizing
`define CSR_FIFO_DEPTH 16
`define CSR_PROG_THRESH 8

// Reads the generator may have unanswered
`define CSR_MAX_OUTSTANDING 8

// Command codes carried in mem_payload_t.cmd
`define CSR_CMD_READ 2'd0
`define CSR_CMD_CFG 2'd1
`define CSR_CMD_DATA 2'd2

// Configuration field selectors, in the low address bits of a CFG word
`define CSR_FIELD_W 2
`define CSR_FIELD_BASE 2'd0
`define CSR_FIELD_START 2'd1
`define CSR_FIELD_END 2'd2

// Byte stride between array elements
`define CSR_WORD_BYTES 4

`endif

// File: csr_engine_pkg.sv
// Shared types of the CSR index engine, imported by the RTL modules and the testbench
package csr_engine_pkg;

    // Plain vectors with a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [31:0] index_t;
    typedef logic [1:0]  cmd_t;

    // Packet body, 66 bits
    typedef struct packed {
        cmd_t  cmd;
        addr_t addr;
        data_t data;
    } mem_payload_t;

    // Strobed packet, 67 bits
    typedef struct packed {
        logic         valid;
        mem_payload_t payload;
    } mem_packet_t;

    // Array base plus index range [start_idx, end_idx)
    typedef struct packed {
        addr_t  base;
        index_t start_idx;
        index_t end_idx;
    } csr_config_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } gen_state_e;

endpackage : csr_engine_pkg

// File: csr_sync_fifo.sv
// First-word-fall-through packet FIFO with a programmable-full flag, instantiated for every queue
`include "csr_engine_cfg.svh"

module csr_sync_fifo #(
    parameter int DEPTH       = `CSR_FIFO_DEPTH,
    parameter int PROG_THRESH = `CSR_PROG_THRESH
) (
    input  logic                         ap_clk,
    input  logic                         areset_csr_engine,
    input  logic                         push_i,
    input  csr_engine_pkg::mem_payload_t din_i,
    input  logic                         pop_i,
    output csr_engine_pkg::mem_payload_t dout_o,
    output logic                         empty_o,
    output logic                         full_o,
    output logic                         prog_full_o
);
    import csr_engine_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_payload_t     mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    // Wrap explicitly so that depths other than powers of two work
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Push into a full FIFO or pop from an empty one is ignored
    assign wr_ok = push_i & ~full_o;
    assign rd_ok = pop_i & ~empty_o;

    assign empty_o     = (count == '0);
    assign full_o      = (count == CNT_W'(DEPTH));
    assign prog_full_o = (count >= CNT_W'(PROG_THRESH));

    // Head entry is always shown
    assign dout_o = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // --------------------------------------------------
    // Pointers and fill count
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : csr_sync_fifo

// File: csr_response_router.sv
// Splits memory responses from the input FIFO into configuration and data strobes by command
`include "csr_engine_cfg.svh"

module csr_response_router (
    input  logic                         ap_clk,
    input  logic                         areset_csr_engine,
    input  csr_engine_pkg::mem_payload_t fifo_dout_i,
    input  logic                         fifo_empty_i,
    input  logic                         stall_i,
    output logic                         fifo_pop_o,
    output csr_engine_pkg::mem_packet_t  cfg_pkt_o,
    output csr_engine_pkg::mem_packet_t  data_pkt_o
);
    import csr_engine_pkg::*;

    cmd_t head_cmd;
    logic take_cfg;
    logic take_data;

    // Hold the head back while the downstream queue is near full
    assign fifo_pop_o = ~fifo_empty_i & ~stall_i;

    assign head_cmd  = fifo_dout_i.cmd;
    assign take_cfg  = fifo_pop_o & (head_cmd == `CSR_CMD_CFG);
    assign take_data = fifo_pop_o & (head_cmd == `CSR_CMD_DATA);

    // --------------------------------------------------
    // Registered strobes
    // --------------------------------------------------
    // Anything that is neither CFG nor DATA is popped and dropped
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_pkt_o.valid  <= 1'b0;
            data_pkt_o.valid <= 1'b0;
        end else begin
            cfg_pkt_o.valid  <= take_cfg;
            data_pkt_o.valid <= take_data;
        end
    end

    // Same word on both sides, only the valid picks the destination
    always_ff @(posedge ap_clk) begin
        cfg_pkt_o.payload  <= fifo_dout_i;
        data_pkt_o.payload <= fifo_dout_i;
    end

endmodule : csr_response_router

// File: csr_configure_memory.sv
// Collects the base, start and end configuration words and holds them for the index generator
`include "csr_engine_cfg.svh"

module csr_configure_memory (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  csr_engine_pkg::mem_packet_t cfg_pkt_i,
    input  logic                        cfg_take_i,
    output csr_engine_pkg::csr_config_t cfg_o,
    output logic                        cfg_valid_o
);
    import csr_engine_pkg::*;

    csr_config_t            cfg_q;
    logic [`CSR_FIELD_W-1:0] field;
    logic                   end_write;

    // Field selector sits in the low address bits
    assign field     = cfg_pkt_i.payload.addr[`CSR_FIELD_W-1:0];
    assign end_write = cfg_pkt_i.valid & (field == `CSR_FIELD_END);

    assign cfg_o = cfg_q;

    always_ff @(posedge ap_clk) begin
        if (cfg_pkt_i.valid) begin
            case (field)
                `CSR_FIELD_BASE:  cfg_q.base      <= cfg_pkt_i.payload.data;
                `CSR_FIELD_START: cfg_q.start_idx <= cfg_pkt_i.payload.data;
                `CSR_FIELD_END:   cfg_q.end_idx   <= cfg_pkt_i.payload.data;
                default:          cfg_q           <= cfg_q;
            endcase
        end
    end

    // --------------------------------------------------
    // Configuration ready flag
    // --------------------------------------------------
    // END word closes a set, a new END wins over a take in the same cycle
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_valid_o <= 1'b0;
        end else if (end_write) begin
            cfg_valid_o <= 1'b1;
        end else if (cfg_take_i) begin
            cfg_valid_o <= 1'b0;
        end
    end

endmodule : csr_configure_memory

// File: csr_index_generator.sv
// Walks the configured index range, issues credit-limited reads and forwards data as engine requests
`include "csr_engine_cfg.svh"

module csr_index_generator (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  csr_engine_pkg::csr_config_t cfg_i,
    input  logic                        cfg_valid_i,
    output logic                        cfg_take_o,
    input  csr_engine_pkg::mem_packet_t data_pkt_i,
    input  logic                        mem_req_stall_i,
    output csr_engine_pkg::mem_packet_t mem_req_o,
    output csr_engine_pkg::mem_packet_t eng_req_o,
    output logic                        done_o
);
    import csr_engine_pkg::*;

    localparam int CRED_W = $clog2(`CSR_MAX_OUTSTANDING + 1);

    gen_state_e        state;
    csr_config_t       cfg_q;
    index_t            cur_idx;
    addr_t             rd_addr;
    logic [CRED_W-1:0] outstanding;
    logic              issue;
    logic              last_issue;
    logic              data_ret;

    assign cfg_take_o = (state == IDLE) & cfg_valid_i;
    assign done_o     = (state == IDLE);

    // One read per cycle, only with a free credit and room downstream
    assign issue = (state == RUN) & ~mem_req_stall_i &
                   (outstanding < CRED_W'(`CSR_MAX_OUTSTANDING));
    assign last_issue = issue & (index_t'(cur_idx + 1'b1) == cfg_q.end_idx);

    // Element address
    assign rd_addr = cfg_q.base + addr_t'(cur_idx * `CSR_WORD_BYTES);

    // Stray data with no read pending does not underflow the credits
    assign data_ret = data_pkt_i.valid & (outstanding != '0);

    // --------------------------------------------------
    // Range FSM
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // Empty or reversed range is taken and dropped
                    if (cfg_take_o && (cfg_i.start_idx < cfg_i.end_idx)) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (last_issue) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (outstanding == '0) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (cfg_take_o) begin
            cfg_q   <= cfg_i;
            cur_idx <= cfg_i.start_idx;
        end else if (issue) begin
            cur_idx <= cur_idx + 1'b1;
        end
    end

    // Unanswered reads
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            outstanding <= '0;
        end else begin
            case ({issue, data_ret})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // --------------------------------------------------
    // Request registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            mem_req_o.valid <= 1'b0;
            eng_req_o.valid <= 1'b0;
        end else begin
            mem_req_o.valid <= issue;
            eng_req_o.valid <= data_pkt_i.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        mem_req_o.payload.cmd  <= `CSR_CMD_READ;
        mem_req_o.payload.addr <= rd_addr;
        mem_req_o.payload.data <= '0;
        // Router only passes DATA, so the word goes on unchanged
        eng_req_o.payload      <= data_pkt_i.payload;
    end

endmodule : csr_index_generator

// File: csr_engine_top.sv
// Top level of the CSR index engine: registered ports around the FIFOs, router and stages
`include "csr_engine_cfg.svh"

module csr_engine_top (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  csr_engine_pkg::mem_packet_t response_memory_i,
    input  logic                        request_memory_rd_en_i,
    input  logic                        request_engine_rd_en_i,
    output csr_engine_pkg::mem_packet_t request_memory_o,
    output csr_engine_pkg::mem_packet_t request_engine_o,
    output logic                        done_o
);
    import csr_engine_pkg::*;

    mem_packet_t  response_memory_q;
    logic         mem_rd_en_q;
    logic         eng_rd_en_q;

    mem_payload_t resp_dout;
    logic         resp_empty;
    logic         resp_pop;

    mem_payload_t mem_req_dout;
    logic         mem_req_empty;
    logic         mem_req_prog_full;
    logic         mem_req_pop;

    mem_payload_t eng_req_dout;
    logic         eng_req_empty;
    logic         eng_req_prog_full;
    logic         eng_req_pop;

    mem_packet_t  cfg_pkt;
    mem_packet_t  data_pkt;
    mem_packet_t  mem_req;
    mem_packet_t  eng_req;
    csr_config_t  cfg;
    logic         cfg_valid;
    logic         cfg_take;
    logic         gen_done;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            response_memory_q.valid <= 1'b0;
            mem_rd_en_q             <= 1'b0;
            eng_rd_en_q             <= 1'b0;
        end else begin
            response_memory_q.valid <= response_memory_i.valid;
            mem_rd_en_q             <= request_memory_rd_en_i;
            eng_rd_en_q             <= request_engine_rd_en_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_memory_q.payload <= response_memory_i.payload;
    end

    // No back-pressure here, read credits keep this FIFO from overflowing
    csr_sync_fifo #(
        .DEPTH      (`CSR_FIFO_DEPTH ),
        .PROG_THRESH(`CSR_PROG_THRESH)
    ) resp_fifo (
        .ap_clk           (ap_clk                   ),
        .areset_csr_engine(areset_csr_engine        ),
        .push_i           (response_memory_q.valid  ),
        .din_i            (response_memory_q.payload),
        .pop_i            (resp_pop                 ),
        .dout_o           (resp_dout                ),
        .empty_o          (resp_empty               ),
        .full_o           (                         ),
        .prog_full_o      (                         )
    );

    // Router holds off while engine requests back up
    csr_response_router router (
        .ap_clk           (ap_clk           ),
        .areset_csr_engine(areset_csr_engine),
        .fifo_dout_i      (resp_dout        ),
        .fifo_empty_i     (resp_empty       ),
        .stall_i          (eng_req_prog_full),
        .fifo_pop_o       (resp_pop         ),
        .cfg_pkt_o        (cfg_pkt          ),
        .data_pkt_o       (data_pkt         )
    );

    csr_configure_memory configure_memory (
        .ap_clk           (ap_clk           ),
        .areset_csr_engine(areset_csr_engine),
        .cfg_pkt_i        (cfg_pkt          ),
        .cfg_take_i       (cfg_take         ),
        .cfg_o            (cfg              ),
        .cfg_valid_o      (cfg_valid        )
    );

    csr_index_generator generator (
        .ap_clk           (ap_clk           ),
        .areset_csr_engine(areset_csr_engine),
        .cfg_i            (cfg              ),
        .cfg_valid_i      (cfg_valid        ),
        .cfg_take_o       (cfg_take         ),
        .data_pkt_i       (data_pkt         ),
        .mem_req_stall_i  (mem_req_prog_full),
        .mem_req_o        (mem_req          ),
        .eng_req_o        (eng_req          ),
        .done_o           (gen_done         )
    );

    // --------------------------------------------------
    // Request output FIFOs
    // --------------------------------------------------
    assign mem_req_pop = mem_rd_en_q & ~mem_req_empty;
    assign eng_req_pop = eng_rd_en_q & ~eng_req_empty;

    csr_sync_fifo #(
        .DEPTH      (`CSR_FIFO_DEPTH ),
        .PROG_THRESH(`CSR_PROG_THRESH)
    ) mem_req_fifo (
        .ap_clk           (ap_clk           ),
        .areset_csr_engine(areset_csr_engine),
        .push_i           (mem_req.valid    ),
        .din_i            (mem_req.payload  ),
        .pop_i            (mem_req_pop      ),
        .dout_o           (mem_req_dout     ),
        .empty_o          (mem_req_empty    ),
        .full_o           (                 ),
        .prog_full_o      (mem_req_prog_full)
    );

    csr_sync_fifo #(
        .DEPTH      (`CSR_FIFO_DEPTH ),
        .PROG_THRESH(`CSR_PROG_THRESH)
    ) eng_req_fifo (
        .ap_clk           (ap_clk           ),
        .areset_csr_engine(areset_csr_engine),
        .push_i           (eng_req.valid    ),
        .din_i            (eng_req.payload  ),
        .pop_i            (eng_req_pop      ),
        .dout_o           (eng_req_dout     ),
        .empty_o          (eng_req_empty    ),
        .full_o           (                 ),
        .prog_full_o      (eng_req_prog_full)
    );

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------
    // Done waits until both request queues have drained as well
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_memory_o.valid <= 1'b0;
            request_engine_o.valid <= 1'b0;
            done_o                 <= 1'b1;
        end else begin
            request_memory_o.valid <= mem_req_pop;
            request_engine_o.valid <= eng_req_pop;
            done_o                 <= gen_done & mem_req_empty & eng_req_empty;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_memory_o.payload <= mem_req_dout;
        request_engine_o.payload <= eng_req_dout;
    end

endmodule : csr_engine_top

// File: csr_engine_tb_clock.sv
// Testbench clock and reset source for the CSR engine testbench, instantiated by its top module
module csr_engine_tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule : csr_engine_tb_clock

// File: csr_engine_tb.sv
// Self-checking testbench of the CSR engine, run as the simulation top with a memory model
`include "csr_engine_cfg.svh"

module csr_engine_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_engine_pkg::*;

    localparam int    NUM_TESTS     = 8;
    localparam int    SETTLE_CYCLES = 20;
    localparam int    FALL_LIMIT    = 64;
    localparam int    ELEM_BYTES    = 4;
    localparam data_t HASH_SEED     = 32'h3c6ef372;

    logic         ap_clk;
    logic         areset_csr_engine;
    mem_packet_t  response_memory = '0;
    logic         mem_rd_en = 1'b0;
    logic         eng_rd_en = 1'b0;
    mem_packet_t  request_memory;
    mem_packet_t  request_engine;
    logic         done;

    integer       seed;
    int           cycle_cnt = 0;
    int           cycle_limit = 1000;
    int           total_idx;
    int           t;
    addr_t        t_base  [NUM_TESTS];
    index_t       t_start [NUM_TESTS];
    index_t       t_end   [NUM_TESTS];

    string        cur_test = "startup";
    int           test_errors = 0;
    int           checks = 0;
    int           passed_tests = 0;
    int           failed_tests = 0;
    logic         stall_mode = 1'b0;
    logic         done_s = 1'b0;
    logic         done_fell = 1'b0;

    mem_payload_t cfg_q [$];
    addr_t        read_q [$];
    addr_t        exp_addr_q [$];
    mem_payload_t exp_eng_q [$];

    mem_packet_t  drv_pkt;
    addr_t        drv_addr;
    int           resp_gap = -1;
    int           mem_hold = 0;
    int           eng_hold = 0;
    logic         mem_level = 1'b1;
    logic         eng_level = 1'b1;

    csr_engine_tb_clock #(
        .PERIOD_NS   (4),
        .RESET_CYCLES(4)
    ) clock_gen (
        .clk_o  (ap_clk           ),
        .reset_o(areset_csr_engine)
    );

    csr_engine_top dut0 (
        .ap_clk                (ap_clk           ),
        .areset_csr_engine     (areset_csr_engine),
        .response_memory_i     (response_memory  ),
        .request_memory_rd_en_i(mem_rd_en        ),
        .request_engine_rd_en_i(eng_rd_en        ),
        .request_memory_o      (request_memory   ),
        .request_engine_o      (request_engine   ),
        .done_o                (done             )
    );

    // Array contents seen by the memory model
    function automatic data_t mem_hash(input addr_t a);
        data_t h;
        h = a ^ HASH_SEED;
        h = h * 32'h9e3779b1;
        h = h ^ (h >> 15);
        return h;
    endfunction

    function automatic mem_payload_t cfg_word(input logic [1:0] field, input data_t value);
        mem_payload_t w;
        w.cmd  = `CSR_CMD_CFG;
        w.addr = addr_t'(field);
        w.data = value;
        return w;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic report_error(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        test_errors++;
    endtask

    task automatic check_mem_req(input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch %s mem_req: expected %h, actual %h", cur_test, exp, act);
            test_errors++;
        end
    endtask

    // Command and data word of a read request
    task automatic check_read_fields(input cmd_t exp_cmd, input data_t exp_data,
                                     input mem_payload_t act);
        checks++;
        if (act.cmd !== exp_cmd || act.data !== exp_data) begin
            $display("Mismatch %s mem_req fields: expected cmd %h data %h, actual cmd %h data %h",
                     cur_test, exp_cmd, exp_data, act.cmd, act.data);
            test_errors++;
        end
    endtask

    task automatic check_eng_req(input mem_payload_t exp, input mem_payload_t act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch %s eng_req: expected %h, actual %h", cur_test, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_done(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch %s done: expected %b, actual %b", cur_test, exp, act);
            test_errors++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus and memory model
    // --------------------------------------------------
    always @(posedge ap_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end else if (areset_csr_engine) begin
            response_memory <= '0;
            mem_rd_en       <= 1'b0;
            eng_rd_en       <= 1'b0;
        end else begin
            // Configuration words first, then read answers in order
            if (cfg_q.size() > 0) begin
                drv_pkt.valid   = 1'b1;
                drv_pkt.payload = cfg_q.pop_front();
                response_memory <= drv_pkt;
            end else if (read_q.size() > 0) begin
                if (resp_gap < 0) begin
                    resp_gap = $unsigned($random(seed)) % 4;
                end
                if (resp_gap == 0) begin
                    drv_addr             = read_q.pop_front();
                    drv_pkt.valid        = 1'b1;
                    drv_pkt.payload.cmd  = `CSR_CMD_DATA;
                    drv_pkt.payload.addr = drv_addr;
                    drv_pkt.payload.data = mem_hash(drv_addr);
                    response_memory <= drv_pkt;
                    resp_gap = -1;
                end else begin
                    resp_gap = resp_gap - 1;
                    response_memory <= '0;
                end
            end else begin
                response_memory <= '0;
            end

            // Consumers go quiet for random stretches
            if (stall_mode) begin
                if (mem_hold == 0) begin
                    mem_level = ($unsigned($random(seed)) % 3) != 0;
                    mem_hold  = 1 + $unsigned($random(seed)) % 8;
                end
                if (eng_hold == 0) begin
                    eng_level = ($unsigned($random(seed)) % 3) != 0;
                    eng_hold  = 1 + $unsigned($random(seed)) % 8;
                end
                mem_hold = mem_hold - 1;
                eng_hold = eng_hold - 1;
                mem_rd_en <= mem_level;
                eng_rd_en <= eng_level;
            end else begin
                mem_rd_en <= 1'b1;
                eng_rd_en <= 1'b1;
            end
        end
    end

    // Output monitor, mid-cycle
    always @(negedge ap_clk) begin
        done_s = done;
        if (done === 1'b0) begin
            done_fell = 1'b1;
        end
        if (request_memory.valid === 1'b1) begin
            check_read_fields(`CSR_CMD_READ, '0, request_memory.payload);
            if (exp_addr_q.size() == 0) begin
                report_error($sformatf("unexpected memory read at %h",
                                       request_memory.payload.addr));
            end else begin
                check_mem_req(exp_addr_q.pop_front(), request_memory.payload.addr);
            end
            read_q.push_back(request_memory.payload.addr);
        end
        if (request_engine.valid === 1'b1) begin
            if (exp_eng_q.size() == 0) begin
                report_error($sformatf("unexpected engine request %h",
                                       request_engine.payload));
            end else begin
                check_eng_req(exp_eng_q.pop_front(), request_engine.payload);
            end
        end
    end

    // --------------------------------------------------
    // Test sequencing
    // --------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge ap_clk);
    endtask

    task automatic send_config(input addr_t base, input index_t s, input index_t e,
                               input logic stall);
        index_t       i;
        addr_t        elem_addr;
        mem_payload_t exp;
        @(negedge ap_clk);
        // First element sits start words above the base, then one word per index
        elem_addr = base + addr_t'(s) * addr_t'(ELEM_BYTES);
        for (i = s; i < e; i++) begin
            exp.cmd  = `CSR_CMD_DATA;
            exp.addr = elem_addr;
            exp.data = mem_hash(elem_addr);
            exp_addr_q.push_back(exp.addr);
            exp_eng_q.push_back(exp);
            elem_addr = elem_addr + addr_t'(ELEM_BYTES);
        end
        cfg_q.push_back(cfg_word(`CSR_FIELD_BASE, base));
        cfg_q.push_back(cfg_word(`CSR_FIELD_START, s));
        cfg_q.push_back(cfg_word(`CSR_FIELD_END, e));
        done_fell  = 1'b0;
        stall_mode = stall;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("PASS %s", cur_test);
            passed_tests++;
        end else begin
            $display("FAIL %s with %0d errors", cur_test, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    task automatic run_range(input string name, input int idx, input logic stall);
        int n;
        cur_test = name;
        send_config(t_base[idx], t_start[idx], t_end[idx], stall);
        n = 0;
        while (!done_fell && n < FALL_LIMIT) begin
            @(posedge ap_clk);
            n++;
        end
        if (!done_fell) begin
            report_error("done_o stayed high after configuration");
        end else begin
            while (!done_s) begin
                @(posedge ap_clk);
            end
        end
        if (exp_addr_q.size() != 0 || exp_eng_q.size() != 0) begin
            report_error($sformatf("done_o high with %0d reads and %0d engine requests missing",
                                   exp_addr_q.size(), exp_eng_q.size()));
        end
        // Any late request shows up as unexpected here
        wait_cycles(SETTLE_CYCLES);
        @(negedge ap_clk);
        stall_mode = 1'b0;
        exp_addr_q.delete();
        exp_eng_q.delete();
        finish_test();
    endtask

    initial begin
        seed      = 32'hee4278bc;
        total_idx = 0;
        for (t = 1; t < NUM_TESTS; t++) begin
            t_base[t]  = addr_t'($random(seed)) & 32'hffff_fffc;
            t_start[t] = index_t'($unsigned($random(seed)) % 1024);
            t_end[t]   = t_start[t] + index_t'(1 + $unsigned($random(seed)) % 20);
        end
        // Test 6 has an empty range
        t_end[6] = t_start[6];
        for (t = 1; t < NUM_TESTS; t++) begin
            total_idx += int'(t_end[t] - t_start[t]);
        end
        cycle_limit = total_idx * 40 + 1000;

        cur_test = "reset_state";
        while (areset_csr_engine !== 1'b0) begin
            @(negedge ap_clk);
        end
        wait_cycles(16);
        check_done(1'b1, done_s);
        finish_test();

        run_range("range_a", 1, 1'b0);
        run_range("range_b", 2, 1'b0);
        run_range("range_c", 3, 1'b0);
        run_range("backpressure_a", 4, 1'b1);
        run_range("backpressure_b", 5, 1'b1);

        cur_test = "empty_range";
        send_config(t_base[6], t_start[6], t_end[6], 1'b0);
        wait_cycles(30);
        if (done_fell) begin
            report_error("done_o fell for an empty range");
        end
        check_done(1'b1, done_s);
        finish_test();

        run_range("after_empty", 7, 1'b0);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks",
                 passed_tests + failed_tests, passed_tests, failed_tests, checks);
        if (failed_tests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : csr_engine_tb

// File: compile.f
+incdir+.
csr_engine_pkg.sv
csr_sync_fifo.sv
csr_response_router.sv
csr_configure_memory.sv
csr_index_generator.sv
csr_engine_top.sv
csr_engine_tb_clock.sv
csr_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSR engine testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f compile.f --top-module csr_engine_tb -o csr_engine_sim \
    > build.log 2>&1 \
    && ./obj_dir/csr_engine_sim > sim.log 2>&1 \
    || echo "Build or simulation run did not complete, see build.log and sim.log"
grep -qsx "all tests passed" sim.log \
    && echo "PASS: simulation reported success" \
    || { echo "FAIL: simulation did not report success"; exit 1; }
